// ==== Makefile ====
# Verilator build and run for the FP16 dot-product testbench

VERILATOR ?= verilator
TOP       ?= dotp_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== back/dotp_back.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Dot-product back end
// ----------------------------------------------------------------------
module dotp_back (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  dotp_stage_if.back             stage_i,
  output dotp_fmt_pkg::fp_t      result_o,
  output dotp_ctrl_pkg::status_t status_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic                   busy_o
);
  import dotp_fmt_pkg::*;
  import dotp_ctrl_pkg::*;

  // --------------------------------------------------------------------
  // Middle register
  // --------------------------------------------------------------------
  logic                        mid_valid_q, mid_ready, out_valid_q;
  logic                        mid_eff_sub_q, mid_sticky_q, mid_sign_q, mid_special_q;
  logic signed [EXP_WIDTH-1:0] mid_exp_prod_x_q, mid_exp_diff_q, mid_tent_exp_q;
  logic [SHAMT_WIDTH-1:0]      mid_shamt_q;
  logic [SUM_WIDTH-1:0]        mid_sum_q;
  fp_t                         mid_spec_result_q;
  status_t                     mid_spec_status_q;

  // Middle hands over when the output is free or draining
  assign mid_ready     = out_ready_i | ~out_valid_q;
  // Bubble popping
  assign stage_i.ready = mid_ready | ~mid_valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mid_valid_q <= 1'b0;
    end else if (stage_i.ready) begin
      mid_valid_q <= stage_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_i.ready && stage_i.valid) begin
      mid_eff_sub_q     <= stage_i.eff_sub;
      mid_exp_prod_x_q  <= stage_i.exp_prod_x;
      mid_exp_diff_q    <= stage_i.exp_diff;
      mid_tent_exp_q    <= stage_i.tent_exp;
      mid_shamt_q       <= stage_i.addend_shamt;
      mid_sticky_q      <= stage_i.sticky;
      mid_sum_q         <= stage_i.sum;
      mid_sign_q        <= stage_i.final_sign;
      mid_special_q     <= stage_i.is_special;
      mid_spec_result_q <= stage_i.special_result;
      mid_spec_status_q <= stage_i.special_status;
    end
  end

  // --------------------------------------------------------------------
  // Normalization
  // --------------------------------------------------------------------
  logic [LOWER_SUM_WIDTH-1:0]    sum_lower;
  logic [LZC_WIDTH-1:0]          lzc;
  logic                          lzc_zero, carry_shift, sticky_norm;
  logic signed [EXP_WIDTH-1:0]   lz_exp, norm_exp, final_exp;
  logic [SHAMT_WIDTH-1:0]        norm_shamt;
  logic [SUM_WIDTH:0]            sum_shifted;
  logic [PREC_BITS:0]            final_man;
  logic [SUM_WIDTH-PREC_BITS-2:0] sticky_bits;

  assign sum_lower = mid_sum_q[LOWER_SUM_WIDTH-1:0];
  assign lzc_zero  = ~|sum_lower;

  // Highest set bit wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (sum_lower[i]) begin
        lzc = LZC_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
      end
    end
  end

  assign lz_exp = mid_exp_prod_x_q - EXP_WIDTH'(lzc) + EXP_WIDTH'(1);

  always_comb begin
    // Product anchored or deep cancellation
    if ((mid_exp_diff_q <= 0) ||
        (mid_eff_sub_q && (mid_exp_diff_q <= 2) && !mid_sum_q[2*PREC_BITS+3])) begin
      if ((lz_exp >= 0) && !lzc_zero) begin
        norm_shamt = SHAMT_WIDTH'(2 * PREC_BITS + 2 + lzc);
        norm_exp   = lz_exp;
      end else begin
        // Subnormal result, flushed below
        norm_shamt = SHAMT_WIDTH'(2 * PREC_BITS + 2 + mid_exp_prod_x_q);
        norm_exp   = -EXP_WIDTH'(2);
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = mid_shamt_q + SHAMT_WIDTH'(1);
      norm_exp   = mid_tent_exp_q;
    end
  end

  always_comb begin
    {carry_shift, sum_shifted} = {2'b00, mid_sum_q} << norm_shamt;
    if (carry_shift) begin
      sum_shifted = {1'b1, sum_shifted[SUM_WIDTH:1]};
    end
  end

  // One-bit fix-up around the MSB
  always_comb begin
    {final_man, sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                = norm_exp + EXP_WIDTH'(carry_shift);
    if (norm_exp > -1) begin
      if (sum_shifted[SUM_WIDTH]) begin
        {final_man, sticky_bits} = sum_shifted[SUM_WIDTH:1];
        final_exp                = norm_exp + EXP_WIDTH'(1) + EXP_WIDTH'(carry_shift);
      end else if (sum_shifted[SUM_WIDTH-1] && (norm_exp > 0)) begin
        // already normal
        final_exp = norm_exp + EXP_WIDTH'(carry_shift);
      end else if (norm_exp > 1) begin
        {final_man, sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
        final_exp                = norm_exp - EXP_WIDTH'(1);
      end else begin
        final_man = '0;
        final_exp = '0;
      end
    end else if (sum_shifted[SUM_WIDTH] && (norm_exp == -1) && carry_shift) begin
      {final_man, sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                = norm_exp + EXP_WIDTH'(2);
    end else begin
      // Flush to zero
      final_man = '0;
      final_exp = '0;
    end
  end

  assign sticky_norm = (|sticky_bits) | mid_sticky_q;

  // --------------------------------------------------------------------
  // Rounding, selection and output register
  // --------------------------------------------------------------------
  fp_t     rounded_result, result_q;
  status_t rounded_status, status_q;

  dotp_round u_round (
    .final_exponent_i (final_exp),
    .final_mantissa_i (final_man),
    .sticky_i         (sticky_norm),
    .sign_i           (mid_sign_q),
    .eff_sub_i        (mid_eff_sub_q),
    .result_o         (rounded_result),
    .status_o         (rounded_status)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (mid_ready) begin
      out_valid_q <= mid_valid_q;
    end
  end

  // Bypass result wins over the datapath
  always_ff @(posedge clk_i) begin
    if (mid_ready && mid_valid_q) begin
      result_q <= mid_special_q ? mid_spec_result_q : rounded_result;
      status_q <= mid_special_q ? mid_spec_status_q : rounded_status;
    end
  end

  assign result_o    = result_q;
  assign status_o    = status_q;
  assign out_valid_o = out_valid_q;
  assign busy_o      = mid_valid_q | out_valid_q;

endmodule

// ==== back/dotp_round.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// FP16 round to nearest even
// ----------------------------------------------------------------------
module dotp_round (
  input  logic signed [dotp_fmt_pkg::EXP_WIDTH-1:0] final_exponent_i,
  input  logic [dotp_fmt_pkg::PREC_BITS:0]          final_mantissa_i,
  input  logic                                      sticky_i,
  input  logic                                      sign_i,
  input  logic                                      eff_sub_i,
  output dotp_fmt_pkg::fp_t                         result_o,
  output dotp_ctrl_pkg::status_t                    status_o
);
  import dotp_fmt_pkg::*;
  import dotp_ctrl_pkg::*;

  logic                         of_before, of_after, uf_after;
  logic                         round_up, exact_zero;
  logic [1:0]                   rs_bits;
  logic [EXP_BITS-1:0]          pre_exp;
  logic [MAN_BITS-1:0]          pre_man;
  logic [EXP_BITS+MAN_BITS-1:0] pre_abs, rounded_abs;

  // Exponent at the infinity code or above
  assign of_before = final_exponent_i >= 2**EXP_BITS - 1;

  // Overflow clamps to the largest normal and forces rounding up
  assign pre_exp = of_before ? EXP_BITS'(2**EXP_BITS - 2) : final_exponent_i[EXP_BITS-1:0];
  assign pre_man = of_before ? '1 : final_mantissa_i[MAN_BITS:1];
  assign pre_abs = {pre_exp, pre_man};
  assign rs_bits = of_before ? 2'b11 : {final_mantissa_i[0], sticky_i};

  // Ties go to the even LSB
  assign round_up    = rs_bits[1] & (rs_bits[0] | pre_abs[0]);
  assign rounded_abs = pre_abs + {{(EXP_BITS+MAN_BITS-1){1'b0}}, round_up};
  assign exact_zero  = (pre_abs == '0) && (rs_bits == 2'b00);

  // Exact cancellation gives +0
  assign result_o.sign                       = (exact_zero && eff_sub_i) ? 1'b0 : sign_i;
  assign {result_o.exponent, result_o.mantissa} = rounded_abs;

  // Classification after rounding
  assign uf_after = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0);
  assign of_after = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);

  assign status_o.NV = 1'b0;
  assign status_o.DZ = 1'b0;
  assign status_o.OF = of_before | of_after;
  assign status_o.NX = (|rs_bits) | of_before | of_after;
  // Tiny results flag underflow only when inexact
  assign status_o.UF = uf_after & status_o.NX;

endmodule

// ==== bench/dotp_tb.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// FP16 dot-product testbench
// ----------------------------------------------------------------------
module dotp_tb;
  import dotp_ctrl_pkg::*;

  localparam int N_EXACT  = 40;
  localparam int N_LAT    = 4;
  localparam int N_STREAM = 16;
  localparam int N_ITEMS  = 2 * N_EXACT + 7 + N_LAT + N_STREAM;
  // 20 cycles per item plus reset and slack
  localparam int WATCHDOG_CYCLES = 8 + N_ITEMS * 20 + 200;
  localparam int DRAIN_LIMIT     = 50;

  logic             clk_i = 1'b0;
  logic             arst_n_i;
  logic [3:0][15:0] operands_i;
  logic             op_mod_i, in_valid_i, in_ready_o;
  logic [15:0]      result_o;
  status_t          status_o;
  logic             out_valid_o, out_ready_i, busy_o;

  // Scoreboard state
  integer      seed = 32'h6dc9;
  logic [15:0] exp_result_q [$];
  logic [4:0]  exp_status_q [$];
  int          accept_cycle_q [$];
  logic [15:0] pend_result;
  logic [4:0]  pend_status;
  int          cycle = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_errors = 0;
  logic        check_latency, ready_low_seen;
  string       test_name;

  dotp_top uut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .operands_i  (operands_i),
    .op_mod_i    (op_mod_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------
  // Small integers are exact in FP16
  function automatic logic [15:0] int_to_half(input int v);
    int          mag;
    int          e;
    logic [15:0] h;
    if (v == 0) return 16'h0000;
    mag = (v < 0) ? -v : v;
    e   = 0;
    while ((mag >> (e + 1)) != 0) e++;
    h[15]    = (v < 0);
    h[14:10] = 5'(e + 15);
    h[9:0]   = 10'((mag << (10 - e)) & 'h3FF);
    return h;
  endfunction

  function automatic logic [15:0] exact_dot(input int a, b, c, d, input logic neg);
    int   p1;
    int   p2;
    logic s1;
    logic s2;
    p1 = a * b;
    p2 = neg ? -(c * d) : c * d;
    if (p1 + p2 != 0) return int_to_half(p1 + p2);
    // Signs of the products as FP values, integer zero encodes as +0
    s1 = (a < 0) ^ (b < 0);
    s2 = (c < 0) ^ neg ^ (d < 0);
    // Only two negative zeros sum to -0, cancellation gives +0
    return (p1 == 0 && p2 == 0 && s1 && s2) ? 16'h8000 : 16'h0000;
  endfunction

  function automatic int draw_small();
    // Range -8 to 8
    draw_small = $random(seed) % 9;
  endfunction

  // --------------------------------------------------------------------
  // Checks and scoreboard
  // --------------------------------------------------------------------
  task automatic check_value(input string name, input logic [15:0] got, exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Pre-edge values of registered outputs and negedge-driven inputs
  always @(posedge clk_i) begin : monitor
    logic [15:0] exp_res;
    logic [4:0]  exp_st;
    int          acc;
    if (arst_n_i) begin
      // Items in flight decide busy and ready
      check_value("busy_o", 16'(busy_o), 16'(exp_result_q.size() != 0));
      check_value("in_ready_o", 16'(in_ready_o),
                  16'(out_ready_i || exp_result_q.size() < 2));
      if (!in_ready_o) ready_low_seen = 1'b1;
      if (out_valid_o && out_ready_i) begin
        if (exp_result_q.size() == 0) begin
          $display("Output handshake at %0t ns with no item in flight", $time);
          errors++;
        end else begin
          exp_res = exp_result_q.pop_front();
          exp_st  = exp_status_q.pop_front();
          acc     = accept_cycle_q.pop_front();
          check_value("result_o", result_o, exp_res);
          check_value("status_o", 16'(status_o), 16'(exp_st));
          if (check_latency) check_value("latency", 16'(cycle - acc), 16'd2);
        end
      end
      if (in_valid_i && in_ready_o) begin
        exp_result_q.push_back(pend_result);
        exp_status_q.push_back(pend_status);
        accept_cycle_q.push_back(cycle);
      end
      cycle++;
    end
  end

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------
  task automatic send_item(input logic [15:0] a, b, c, d, input logic mod,
                           input logic [15:0] exp_res, input logic [4:0] exp_st);
    @(negedge clk_i);
    operands_i  = {d, c, b, a};
    op_mod_i    = mod;
    pend_result = exp_res;
    pend_status = exp_st;
    in_valid_i  = 1'b1;
    // Ready is settled a moment after the falling edge until the next rising edge
    #1;
    while (!in_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
  endtask

  task automatic send_random(input logic mod);
    int a, b, c, d;
    a = draw_small();
    b = draw_small();
    c = draw_small();
    d = draw_small();
    send_item(int_to_half(a), int_to_half(b), int_to_half(c), int_to_half(d), mod,
              exact_dot(a, b, c, d, mod), 5'b00000);
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk_i);
    in_valid_i = 1'b0;
    while ((exp_result_q.size() != 0 || busy_o) && waited < DRAIN_LIMIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (waited >= DRAIN_LIMIT) begin
      $display("Pipeline did not drain within %0d cycles at %0t ns", DRAIN_LIMIT, $time);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    $display("Test %-14s done, %0d errors", test_name, errors - test_errors);
  endtask

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  initial begin
    arst_n_i       = 1'b0;
    operands_i     = '0;
    op_mod_i       = 1'b0;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    pend_result    = '0;
    pend_status    = '0;
    check_latency  = 1'b1;
    ready_low_seen = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    begin_test("reset");
    @(negedge clk_i);
    check_value("out_valid_o", 16'(out_valid_o), 16'h0);
    check_value("busy_o", 16'(busy_o), 16'h0);
    check_value("in_ready_o", 16'(in_ready_o), 16'h1);
    end_test();

    begin_test("exact_dotp");
    for (int i = 0; i < N_EXACT; i++) send_random(1'b0);
    wait_idle();
    end_test();

    begin_test("exact_dotpn");
    for (int i = 0; i < N_EXACT; i++) send_random(1'b1);
    wait_idle();
    end_test();

    // 1 + 2^-12 is a quarter ulp above 1.0
    begin_test("inexact");
    send_item(16'h3C00, 16'h3C00, 16'h0C00, 16'h3C00, 1'b0, 16'h3C00, 5'b00001);
    wait_idle();
    end_test();

    begin_test("overflow");
    send_item(16'h7BFF, 16'h4000, 16'h0000, 16'h0000, 1'b0, 16'h7C00, 5'b00101);
    wait_idle();
    end_test();

    begin_test("specials");
    // inf times zero
    send_item(16'h7C00, 16'h0000, 16'h3C00, 16'h3C00, 1'b0, QNAN_VALUE, 5'b10000);
    // Signalling and quiet NaN
    send_item(16'h7D00, 16'h3C00, 16'h3C00, 16'h3C00, 1'b0, QNAN_VALUE, 5'b10000);
    send_item(16'h7E00, 16'h3C00, 16'h3C00, 16'h3C00, 1'b0, QNAN_VALUE, 5'b00000);
    // Opposite infinities
    send_item(16'h7C00, 16'h3C00, 16'hFC00, 16'h3C00, 1'b0, QNAN_VALUE, 5'b10000);
    send_item(16'h7C00, 16'hBC00, 16'h3C00, 16'h3C00, 1'b0, 16'hFC00, 5'b00000);
    wait_idle();
    end_test();

    // Isolated items, latency checked in the monitor
    begin_test("latency");
    for (int i = 0; i < N_LAT; i++) begin
      send_random(1'(i));
      wait_idle();
    end
    end_test();

    begin_test("backpressure");
    check_latency  = 1'b0;
    ready_low_seen = 1'b0;
    fork
      begin
        for (int i = 0; i < N_STREAM; i++) send_random(1'(i));
      end
      begin
        repeat (3) @(negedge clk_i);
        out_ready_i = 1'b0;
        repeat (10) @(negedge clk_i);
        out_ready_i = 1'b1;
      end
    join
    wait_idle();
    checks++;
    assert (ready_low_seen) else begin
      $display("in_ready_o never dropped while the output was stalled");
      errors++;
    end
    check_latency = 1'b1;
    end_test();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== common/dotp_ctrl_pkg.sv ====
// ----------------------------------------------------------------------
// Dot-product status and control types
// ----------------------------------------------------------------------
package dotp_ctrl_pkg;

  // Exception flags in RISC-V fflags order
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // Kind of bypass result chosen before the datapath
  typedef enum logic [1:0] {
    NONE,
    QNAN,
    INF
  } special_e;

  // Canonical quiet NaN
  localparam logic [15:0] QNAN_VALUE = 16'h7E00;

endpackage

// ==== common/dotp_fmt_pkg.sv ====
// ----------------------------------------------------------------------
// FP16 format definitions
// ----------------------------------------------------------------------
package dotp_fmt_pkg;

  // Binary16 field widths
  localparam int EXP_BITS = 5;
  localparam int MAN_BITS = 10;
  localparam int WIDTH    = 16;
  localparam int BIAS     = 15;

  // Mantissa width with the implicit bit
  localparam int PREC_BITS = MAN_BITS + 1;

  // Signed internal exponent, wide enough for product sums and LZC offsets
  localparam int EXP_WIDTH = EXP_BITS + 2;

  // Adder holds two 2p-bit products plus guard and round room
  localparam int SUM_WIDTH = 4 * PREC_BITS + 4;

  // Only the lower 2p+3 bits are searched on cancellation
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  localparam int LZC_WIDTH       = 5;

  // Shift amounts reach 4p+4
  localparam int SHAMT_WIDTH = 6;

  // Encoded operand
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Operand class
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

endpackage

// ==== common/dotp_stage_if.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Adder stage channel
// ----------------------------------------------------------------------
interface dotp_stage_if;
  import dotp_fmt_pkg::*;
  import dotp_ctrl_pkg::*;

  // Adder results
  logic                        eff_sub;
  logic signed [EXP_WIDTH-1:0] exp_prod_x;
  logic signed [EXP_WIDTH-1:0] exp_diff;
  logic signed [EXP_WIDTH-1:0] tent_exp;
  logic [SHAMT_WIDTH-1:0]      addend_shamt;
  logic                        sticky;
  logic [SUM_WIDTH-1:0]        sum;
  logic                        final_sign;

  // Bypass path
  logic                        is_special;
  fp_t                         special_result;
  status_t                     special_status;

  // Handshake
  logic                        valid;
  logic                        ready;

  modport front (
    output eff_sub, exp_prod_x, exp_diff, tent_exp, addend_shamt, sticky, sum,
           final_sign, is_special, special_result, special_status, valid,
    input  ready
  );

  modport back (
    input  eff_sub, exp_prod_x, exp_diff, tent_exp, addend_shamt, sticky, sum,
           final_sign, is_special, special_result, special_status, valid,
    output ready
  );

endinterface

// ==== compile.f ====
common/dotp_fmt_pkg.sv
common/dotp_ctrl_pkg.sv
common/dotp_stage_if.sv
front/dotp_classify.sv
front/dotp_front.sv
back/dotp_round.sv
back/dotp_back.sv
design/dotp_top.sv
bench/dotp_tb.sv

// ==== design/dotp_top.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// FP16 fused dot-product unit
// ----------------------------------------------------------------------
module dotp_top (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  // Input side
  input  logic [3:0][dotp_fmt_pkg::WIDTH-1:0]   operands_i,
  input  logic                                  op_mod_i,
  input  logic                                  in_valid_i,
  output logic                                  in_ready_o,
  // Output side
  output logic [dotp_fmt_pkg::WIDTH-1:0]        result_o,
  output dotp_ctrl_pkg::status_t                status_o,
  output logic                                  out_valid_o,
  input  logic                                  out_ready_i,
  // Items in flight
  output logic                                  busy_o
);

  dotp_stage_if stage_if ();

  // Combinational front, registers live in the back
  dotp_front u_front (
    .operands_i (operands_i),
    .op_mod_i   (op_mod_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .stage_o    (stage_if.front)
  );

  dotp_back u_back (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .stage_i     (stage_if.back),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

endmodule

// ==== front/dotp_classify.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// FP16 operand classifier
// ----------------------------------------------------------------------
module dotp_classify (
  input  dotp_fmt_pkg::fp_t      [3:0] operands_i,
  output dotp_fmt_pkg::fp_info_t [3:0] info_o
);
  import dotp_fmt_pkg::*;

  logic [3:0] exp_zero;
  logic [3:0] exp_ones;
  logic [3:0] man_zero;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      // Field patterns
      exp_zero[i] = (operands_i[i].exponent == '0);
      exp_ones[i] = (operands_i[i].exponent == '1);
      man_zero[i] = (operands_i[i].mantissa == '0);

      info_o[i].is_normal    = !exp_zero[i] && !exp_ones[i];
      info_o[i].is_subnormal = exp_zero[i] && !man_zero[i];
      info_o[i].is_zero      = exp_zero[i] && man_zero[i];
      info_o[i].is_inf       = exp_ones[i] && man_zero[i];
      info_o[i].is_nan       = exp_ones[i] && !man_zero[i];
      // Quiet bit clear means signalling
      info_o[i].is_signalling = exp_ones[i] && !man_zero[i]
                                && !operands_i[i].mantissa[MAN_BITS-1];
    end
  end

endmodule

// ==== front/dotp_front.sv ====
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// Dot-product front end
// ----------------------------------------------------------------------
module dotp_front (
  input  dotp_fmt_pkg::fp_t [3:0] operands_i,
  input  logic                    op_mod_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  dotp_stage_if.front             stage_o
);
  import dotp_fmt_pkg::*;
  import dotp_ctrl_pkg::*;

  fp_info_t [3:0] info;
  fp_t      [3:0] ops;

  dotp_classify u_classify (
    .operands_i (operands_i),
    .info_o     (info)
  );

  // DOTPN flips operand c and so the second product
  always_comb begin
    ops         = operands_i;
    ops[2].sign = operands_i[2].sign ^ op_mod_i;
  end

  // --------------------------------------------------------------------
  // Special cases
  // --------------------------------------------------------------------
  logic     any_nan, any_snan, inf_x, inf_y;
  logic     eff_sub, tent_sign, inf_sign;
  special_e spec_kind;
  status_t  spec_status;

  assign any_nan   = |{info[0].is_nan, info[1].is_nan, info[2].is_nan, info[3].is_nan};
  assign any_snan  = |{info[0].is_signalling, info[1].is_signalling,
                       info[2].is_signalling, info[3].is_signalling};
  assign inf_x     = info[0].is_inf | info[1].is_inf;
  assign inf_y     = info[2].is_inf | info[3].is_inf;
  // Products of opposite sign make an effective subtraction
  assign tent_sign = ops[0].sign ^ ops[1].sign;
  assign eff_sub   = tent_sign ^ ops[2].sign ^ ops[3].sign;

  always_comb begin
    spec_kind   = NONE;
    spec_status = '0;
    inf_sign    = tent_sign;
    // inf times zero is invalid even next to a quiet NaN
    if ((info[0].is_inf && info[1].is_zero) || (info[0].is_zero && info[1].is_inf) ||
        (info[2].is_inf && info[3].is_zero) || (info[2].is_zero && info[3].is_inf)) begin
      spec_kind      = QNAN;
      spec_status.NV = 1'b1;
    end else if (any_nan) begin
      spec_kind      = QNAN;
      spec_status.NV = any_snan;
    end else if (inf_x || inf_y) begin
      if (inf_x && inf_y && eff_sub) begin
        // Opposite infinities
        spec_kind      = QNAN;
        spec_status.NV = 1'b1;
      end else begin
        spec_kind = INF;
        inf_sign  = inf_x ? tent_sign : (ops[2].sign ^ ops[3].sign);
      end
    end
  end

  assign stage_o.is_special     = (spec_kind != NONE);
  assign stage_o.special_result = (spec_kind == INF) ?
                                  {inf_sign, {EXP_BITS{1'b1}}, {MAN_BITS{1'b0}}} : QNAN_VALUE;
  assign stage_o.special_status = spec_status;

  // --------------------------------------------------------------------
  // Exponents and mantissa products
  // --------------------------------------------------------------------
  logic signed [EXP_WIDTH-1:0] exp_adj [4];
  logic [PREC_BITS-1:0]        man [4];
  logic signed [EXP_WIDTH-1:0] exp_prod_x, exp_prod_y, exp_diff;
  logic [SHAMT_WIDTH-1:0]      addend_shamt;
  logic [2*PREC_BITS-1:0]      prod_x, prod_y;

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      // Subnormals sit at exponent 1 without the hidden one
      exp_adj[i] = EXP_WIDTH'(ops[i].exponent) + EXP_WIDTH'(info[i].is_subnormal);
      man[i]     = {info[i].is_normal, ops[i].mantissa};
    end
  end

  // Biased product exponents, zero products pinned to the minimum
  assign exp_prod_x = (info[0].is_zero || info[1].is_zero) ? EXP_WIDTH'(2 - BIAS) :
                      exp_adj[0] + exp_adj[1] - EXP_WIDTH'(BIAS);
  assign exp_prod_y = (info[2].is_zero || info[3].is_zero) ? EXP_WIDTH'(2 - BIAS) :
                      exp_adj[2] + exp_adj[3] - EXP_WIDTH'(BIAS);
  assign exp_diff   = exp_prod_y - exp_prod_x;

  // Right shift of product y, saturated on both sides
  always_comb begin
    if (exp_diff <= -2 * PREC_BITS - 1) begin
      addend_shamt = SHAMT_WIDTH'(4 * PREC_BITS + 4);
    end else if (exp_diff <= 2 * PREC_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(2 * PREC_BITS + 2 - exp_diff);
    end else begin
      addend_shamt = '0;
    end
  end

  assign prod_x = man[0] * man[1];
  assign prod_y = man[2] * man[3];

  // --------------------------------------------------------------------
  // Alignment and adder
  // --------------------------------------------------------------------
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;
  logic [SUM_WIDTH-1:0]           prod_x_shifted, addend_shifted;
  logic [SUM_WIDTH:0]             sum_raw;
  logic                           sticky, carry_in;

  // Product x leaves two bits below for round and sticky
  assign prod_x_shifted = SUM_WIDTH'(prod_x) << 2;
  // Up to p bits shifted out of product y fold into sticky
  assign addend_wide    = {prod_y, {(SUM_WIDTH-PREC_BITS){1'b0}}} >> addend_shamt;
  assign sticky         = |addend_wide[PREC_BITS-1:0];
  assign addend_shifted = eff_sub ? ~addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS] :
                                    addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  // Two's complement carry only when nothing went to sticky
  assign carry_in       = eff_sub & ~sticky;
  assign sum_raw        = {1'b0, prod_x_shifted} + {1'b0, addend_shifted}
                          + {{SUM_WIDTH{1'b0}}, carry_in};

  // No carry in a subtraction means a negative sum
  assign stage_o.sum        = (eff_sub && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0] :
                                                                 sum_raw[SUM_WIDTH-1:0];
  assign stage_o.final_sign = eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;

  assign stage_o.eff_sub      = eff_sub;
  assign stage_o.exp_prod_x   = exp_prod_x;
  assign stage_o.exp_diff     = exp_diff;
  assign stage_o.tent_exp     = (exp_diff > 0) ? exp_prod_y : exp_prod_x;
  assign stage_o.addend_shamt = addend_shamt;
  assign stage_o.sticky       = sticky;

  // Combinational stage
  assign stage_o.valid = in_valid_i;
  assign in_ready_o    = stage_o.ready;

endmodule
